/* tb.f */
logic/rvPkg.sv
logic/mainDeco.sv
logic/aluDeco.sv
logic/immExtend.sv
logic/regFile.sv
logic/alu.sv
logic/rvCore.sv
verif/rvCoreAssertions.sv
verif/rvCoreTb.sv

/* Bender.yml */
package:
  name: rvCore

sources:
  - logic/rvPkg.sv
  - logic/mainDeco.sv
  - logic/aluDeco.sv
  - logic/immExtend.sv
  - logic/regFile.sv
  - logic/alu.sv
  - logic/rvCore.sv
  - target: test
    files:
      - verif/rvCoreAssertions.sv
      - verif/rvCoreTb.sv

/* verif/rvCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;

    localparam int clkPeriod = 8;
    localparam int rstCycles = 8;
    localparam int numRows = 13;
    localparam logic [31:0] bootAddr = 32'h0000_0000;
    localparam logic [31:0] poisonAddr = 32'h0000_07f0;
    localparam logic [31:0] firstStoreAddr = 32'h0000_07e0;

    typedef struct {
        string       op;
        logic [31:0] a;
        logic [31:0] b;
        int          slot;
    } rowT;

    logic        clk;
    logic        arstN;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic [31:0] dataAddr;
    logic [31:0] writeData;
    logic        memWrite;
    logic [31:0] readData;

    logic [31:0] imem [256];
    logic [31:0] dmem [512];

    string opNames [numRows] = '{"add", "sub", "and", "or", "slt", "addi", "andi", "ori",
                                 "slti", "lw", "beqTaken", "beqNot", "jal"};
    rowT tab [numRows];

    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    int          expRow [$];
    bit          expLast [$];

    int rowErr [numRows];
    int seed = 32'h5503_133a;
    int pcW = 0;
    int progLen = 0;
    int passedTests = 0;
    int failedTests = 0;
    int strayErrors = 0;

    rvCore #(.resetAddr(bootAddr)) dut_i (
        .clk       (clk),
        .arstN     (arstN),
        .instrAddr (instrAddr),
        .instr     (instr),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .memWrite  (memWrite),
        .readData  (readData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // ########################################
    // memory models
    // ########################################
    assign instr    = imem[instrAddr[9:2]];
    assign readData = dmem[dataAddr[10:2]];

    always @(posedge clk)
    begin
        if (memWrite)
        begin
            dmem[dataAddr[10:2]] <= writeData;
        end
    end

    // ########################################
    // assembler helpers
    // ########################################
    function automatic logic [31:0] rWord(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, rvPkg::opRType};
    endfunction

    function automatic logic [31:0] iWord(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // store with base x0
    function automatic logic [31:0] swWord(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rvPkg::opStore};
    endfunction

    function automatic logic [31:0] beqWord(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], rvPkg::opBranch};
    endfunction

    function automatic logic [31:0] jalWord(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvPkg::opJal};
    endfunction

    function automatic logic [2:0] funct3Of(input string op);
        if (op == "slt" || op == "slti")
            return 3'b010;
        else if (op == "or" || op == "ori")
            return 3'b110;
        else if (op == "and" || op == "andi")
            return 3'b111;
        else
            return 3'b000;
    endfunction

    // reference arithmetic per RV32I rules
    function automatic logic [31:0] expectedResult(input string op, input logic [31:0] a,
                                                   input logic [31:0] b);
        if (op == "add" || op == "addi")
            return a + b;
        else if (op == "sub")
            return a - b;
        else if (op == "and" || op == "andi")
            return a & b;
        else if (op == "or" || op == "ori")
            return a | b;
        // the negative operand is the smaller one
        else if (a[31] != b[31])
            return {31'd0, a[31]};
        else
            return (a < b) ? 32'd1 : 32'd0;
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[pcW] = word;
        pcW++;
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data,
                               input int row, input bit last);
        expAddr.push_back(addr);
        expData.push_back(data);
        expRow.push_back(row);
        expLast.push_back(last);
    endtask

    // ########################################
    // table to program
    // ########################################
    task automatic buildProgram();
        logic [11:0] r12;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] jalAddr;
        string       op;
        // boot store is decoded while reset is still low
        emit(swWord(firstStoreAddr[11:0], 5'd0));
        expectStore(firstStoreAddr, 32'd0, 0, 1'b0);
        for (int r = 0; r < numRows; r++)
        begin
            op = opNames[r];
            r12 = 12'($random(seed));
            a = {{20{r12[11]}}, r12};
            r12 = 12'($random(seed));
            b = {{20{r12[11]}}, r12};
            if (op == "slt" && (a[31] == b[31]))
                b = ~b;
            if ((op == "addi" || op == "andi" || op == "ori" || op == "slti") && !b[31])
                b = ~b;
            if (op == "beqTaken")
                b = a;
            if (op == "beqNot")
                b = ~a;
            tab[r] = '{op: op, a: a, b: b, slot: 4 * r};
            addr = 32'(tab[r].slot * 4);

            emit(iWord(a[11:0], 5'd0, 3'b000, 5'd1, rvPkg::opIType));
            emit(iWord(b[11:0], 5'd0, 3'b000, 5'd2, rvPkg::opIType));
            if (op == "lw")
            begin
                emit(swWord(addr[11:0], 5'd1));
                emit(iWord(addr[11:0], 5'd0, 3'b010, 5'd3, rvPkg::opLoad));
                emit(swWord(addr[11:0] + 12'd4, 5'd3));
                expectStore(addr, a, r, 1'b0);
                expectStore(addr + 32'd4, a, r, 1'b1);
            end
            else if (op == "beqTaken")
            begin
                emit(beqWord(13'd8));
                emit(swWord(poisonAddr[11:0], 5'd1));
                emit(swWord(addr[11:0], 5'd1));
                expectStore(addr, a, r, 1'b1);
            end
            else if (op == "beqNot")
            begin
                emit(beqWord(13'd8));
                emit(swWord(addr[11:0], 5'd1));
                emit(swWord(addr[11:0] + 12'd4, 5'd2));
                expectStore(addr, a, r, 1'b0);
                expectStore(addr + 32'd4, b, r, 1'b1);
            end
            else if (op == "jal")
            begin
                jalAddr = 32'(pcW * 4);
                emit(jalWord(21'd8, 5'd3));
                emit(swWord(poisonAddr[11:0], 5'd0));
                emit(swWord(addr[11:0], 5'd3));
                expectStore(addr, jalAddr + 32'd4, r, 1'b1);
            end
            else
            begin
                if (op == "add" || op == "sub" || op == "and" || op == "or" || op == "slt")
                    emit(rWord((op == "sub") ? 7'h20 : 7'h00, funct3Of(op)));
                else
                    emit(iWord(b[11:0], 5'd1, funct3Of(op), 5'd3, rvPkg::opIType));
                emit(swWord(addr[11:0], 5'd3));
                expectStore(addr, expectedResult(op, a, b), r, 1'b1);
            end
        end
        // park on a self loop
        emit(jalWord(21'd0, 5'd0));
    endtask

    // ########################################
    // store monitor
    // ########################################
    task automatic checkStore();
        logic [31:0] eAddr;
        logic [31:0] eData;
        int          row;
        bit          last;
        if (dataAddr == poisonAddr)
        begin
            strayErrors++;
            $display("store to poison slot at %0t, a skipped instruction ran", $time);
        end
        else if (expAddr.size() == 0)
        begin
            strayErrors++;
            $display("unexpected store to %h at %0t", dataAddr, $time);
        end
        else
        begin
            eAddr = expAddr.pop_front();
            eData = expData.pop_front();
            row = expRow.pop_front();
            last = expLast.pop_front();
            if (dataAddr !== eAddr)
            begin
                rowErr[row]++;
                $display("Mismatch at %0t: dataAddr expected %h got %h", $time, eAddr, dataAddr);
            end
            if (writeData !== eData)
            begin
                rowErr[row]++;
                $display("Mismatch at %0t: writeData expected %h got %h", $time, eData,
                         writeData);
            end
            if (last)
            begin
                if (rowErr[row] == 0)
                    passedTests++;
                else
                    failedTests++;
                $display("test %0d %s: %s", row, tab[row].op,
                         (rowErr[row] == 0) ? "passed" : "failed");
            end
        end
    endtask

    // outputs are settled mid cycle
    always @(negedge clk)
    begin
        if (!arstN && memWrite)
        begin
            strayErrors++;
            $display("store attempted during reset at %0t", $time);
        end
        else if (arstN && memWrite)
        begin
            checkStore();
        end
    end

    initial
    begin
        wait (progLen != 0);
        #((rstCycles + 2 * progLen) * clkPeriod);
        $display("timeout, %0d expected stores never seen", expAddr.size());
        $display("Something failed");
        $finish;
    end

    initial
    begin
        clk = 1'b0;
        arstN = 1'b0;
        for (int k = 0; k < 256; k++)
        begin
            imem[k] = {k[24:0], 7'h00};
        end
        for (int k = 0; k < 512; k++)
        begin
            dmem[k] = {k[15:0], ~k[15:0]};
        end
        buildProgram();
        progLen = pcW;

        repeat (rstCycles) @(posedge clk);
        arstN <= 1'b1;

        // first fetch comes from the boot address
        @(negedge clk);
        if (instrAddr !== bootAddr)
        begin
            strayErrors++;
            $display("Mismatch at %0t: instrAddr expected %h got %h", $time, bootAddr,
                     instrAddr);
        end

        while (expAddr.size() != 0)
        begin
            @(negedge clk);
        end
        // catch stray stores after the last row
        repeat (4) @(negedge clk);

        $display("tests passed %0d, failed %0d, other errors %0d", passedTests, failedTests,
                 strayErrors);
        if (failedTests == 0 && strayErrors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/rvCoreAssertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCoreAssertions (
    input wire logic        clk,
    input wire logic        arstN,
    input wire logic [31:0] instrAddr,
    input wire logic [31:0] pc,
    input wire logic        memWrite,
    input wire logic        branch,
    input wire logic        jump
);

    fetchAligned: assert property (@(posedge clk) disable iff (!arstN)
        instrAddr[1:0] == 2'b00)
        else $error("instrAddr not word aligned");

    noStoreInReset: assert property (@(posedge clk) !arstN |-> !memWrite)
        else $error("memWrite high during reset");

    memWriteKnown: assert property (@(posedge clk) disable iff (!arstN)
        !$isunknown(memWrite))
        else $error("memWrite unknown");

    // release edge excluded by the sampled reset
    pcSequential: assert property (@(posedge clk) disable iff (!arstN)
        (arstN && !branch && !jump) |=> (pc == $past(pc) + 32'd4))
        else $error("pc did not advance by 4");

endmodule

bind rvCore rvCoreAssertions coreChecks (
    .clk       (clk),
    .arstN     (arstN),
    .instrAddr (instrAddr),
    .pc        (pc),
    .memWrite  (memWrite),
    .branch    (branch),
    .jump      (jump)
);

`default_nettype wire

/* logic/rvCore.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
    parameter logic [31:0] resetAddr = 32'h0000_0000
) (
    input  wire logic          clk,
    input  wire logic          arstN,
    output logic [31:0]        instrAddr,
    input  wire logic [31:0]   instr,
    output logic [31:0]        dataAddr,
    output logic [31:0]        writeData,
    output logic               memWrite,
    input  wire logic [31:0]   readData
);

    rvPkg::rvInstr instrView;

    logic [31:0] pc;
    logic [31:0] pcNext;
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;
    logic        pcSrc;

    logic                            branch;
    logic                            jump;
    logic [rvPkg::resSrcW-1:0]       resSrc;
    logic                            memWriteDec;
    logic                            aluSrc;
    logic [rvPkg::immSrcW-1:0]       immSrc;
    logic                            regWrite;
    logic [rvPkg::aluOpW-1:0]        aluOp;
    logic [rvPkg::aluCtrlW-1:0]      aluCtrl;

    logic [31:0] immExt;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] srcB;
    logic [31:0] aluResult;
    logic        zero;
    logic [31:0] result;

    assign instrView = instr;

    // ########################################
    // control
    // ########################################
    mainDeco mainDecoder (
        .op       (instrView.r.opcode),
        .branch   (branch),
        .jump     (jump),
        .resSrc   (resSrc),
        .memWrite (memWriteDec),
        .aluSrc   (aluSrc),
        .immSrc   (immSrc),
        .regWrite (regWrite),
        .aluOp    (aluOp)
    );

    aluDeco aluDecoder (
        .aluOp    (aluOp),
        .funct3   (instrView.r.funct3),
        .funct7b5 (instrView.r.funct7[5]),
        .opb5     (instrView.r.opcode[5]),
        .aluCtrl  (aluCtrl)
    );

    // ########################################
    // program counter
    // ########################################
    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + immExt;
    assign pcSrc    = jump | (branch & zero);
    assign pcNext   = pcSrc ? pcTarget : pcPlus4;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pc <= resetAddr;
        end
        else
        begin
            pc <= pcNext;
        end
    end

    assign instrAddr = pc;

    // ########################################
    // datapath
    // ########################################
    immExtend immExtender (
        .instr  (instrView),
        .immSrc (immSrc),
        .immExt (immExt)
    );

    regFile registers (
        .clk   (clk),
        .arstN (arstN),
        .ra1   (instrView.r.rs1),
        .ra2   (instrView.r.rs2),
        .wa    (instrView.r.rd),
        .we    (regWrite),
        .wd    (result),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    assign srcB = aluSrc ? immExt : rd2;

    alu aluUnit (
        .a       (rd1),
        .b       (srcB),
        .aluCtrl (aluCtrl),
        .result  (aluResult),
        .zero    (zero)
    );

    // writeback select
    always_comb
    begin
        case (resSrc)
            rvPkg::resMem:     result = readData;
            rvPkg::resPcPlus4: result = pcPlus4;
            default:           result = aluResult;
        endcase
    end

    assign dataAddr  = aluResult;
    assign writeData = rd2;
    // no stores while held in reset
    assign memWrite  = memWriteDec & arstN;

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic [31:0]                   a,
    input  wire logic [31:0]                   b,
    input  wire logic [rvPkg::aluCtrlW-1:0]    aluCtrl,
    output logic [31:0]                        result,
    output logic                               zero
);

    always_comb
    begin
        case (aluCtrl)
            rvPkg::aluAdd:
            begin
                result = a + b;
            end
            rvPkg::aluSub:
            begin
                result = a - b;
            end
            rvPkg::aluAnd:
            begin
                result = a & b;
            end
            rvPkg::aluOr:
            begin
                result = a | b;
            end
            rvPkg::aluSlt:
            begin
                // signed compare
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            default:
            begin
                result = a + b;
            end
        endcase
    end

    // used by beq after a subtraction
    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic          clk,
    input  wire logic          arstN,
    input  wire logic [4:0]    ra1,
    input  wire logic [4:0]    ra2,
    input  wire logic [4:0]    wa,
    input  wire logic          we,
    input  wire logic [31:0]   wd,
    output logic [31:0]        rd1,
    output logic [31:0]        rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int k = 0; k < 32; k++)
            begin
                regs[k] <= '0;
            end
        end
        else if (we && (wa != 5'd0))
        begin
            regs[wa] <= wd;
        end
    end

    // x0 reads as zero
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

`default_nettype wire

/* logic/immExtend.sv */
`timescale 1ns/1ps
`default_nettype none

module immExtend (
    input  wire rvPkg::rvInstr                instr,
    input  wire logic [rvPkg::immSrcW-1:0]    immSrc,
    output logic [31:0]                       immExt
);

    always_comb
    begin
        case (immSrc)
            rvPkg::immI:
            begin
                immExt = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            rvPkg::immS:
            begin
                immExt = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            end
            rvPkg::immB:
            begin
                immExt = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                          instr.b.imm10To5, instr.b.imm4To1, 1'b0};
            end
            // jal offset reaches 1 MiB each way
            default:
            begin
                immExt = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19To12,
                          instr.j.imm11, instr.j.imm10To1, 1'b0};
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/aluDeco.sv */
`timescale 1ns/1ps
`default_nettype none

module aluDeco (
    input  wire logic [rvPkg::aluOpW-1:0]    aluOp,
    input  wire logic [2:0]                  funct3,
    input  wire logic                        funct7b5,
    input  wire logic                        opb5,
    output logic [rvPkg::aluCtrlW-1:0]       aluCtrl
);

    always_comb
    begin
        aluCtrl = rvPkg::aluAdd;
        case (aluOp)
            rvPkg::aluOpAdd:
            begin
                aluCtrl = rvPkg::aluAdd;
            end
            rvPkg::aluOpSub:
            begin
                aluCtrl = rvPkg::aluSub;
            end
            rvPkg::aluOpFunct:
            begin
                case (funct3)
                    // addi never subtracts
                    3'b000:  aluCtrl = (opb5 && funct7b5) ? rvPkg::aluSub : rvPkg::aluAdd;
                    3'b010:  aluCtrl = rvPkg::aluSlt;
                    3'b110:  aluCtrl = rvPkg::aluOr;
                    3'b111:  aluCtrl = rvPkg::aluAnd;
                    default: aluCtrl = rvPkg::aluAdd;
                endcase
            end
            default:
            begin
                aluCtrl = rvPkg::aluAdd;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/mainDeco.sv */
`timescale 1ns/1ps
`default_nettype none

module mainDeco (
    input  wire logic [6:0]                  op,
    output logic                             branch,
    output logic                             jump,
    output logic [rvPkg::resSrcW-1:0]        resSrc,
    output logic                             memWrite,
    output logic                             aluSrc,
    output logic [rvPkg::immSrcW-1:0]        immSrc,
    output logic                             regWrite,
    output logic [rvPkg::aluOpW-1:0]         aluOp
);

    always_comb
    begin
        // unknown opcodes fall through as no-ops
        branch   = 1'b0;
        jump     = 1'b0;
        resSrc   = rvPkg::resAlu;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        immSrc   = rvPkg::immI;
        regWrite = 1'b0;
        aluOp    = rvPkg::aluOpAdd;

        case (op)
            rvPkg::opLoad:
            begin
                resSrc   = rvPkg::resMem;
                aluSrc   = 1'b1;
                immSrc   = rvPkg::immI;
                regWrite = 1'b1;
                aluOp    = rvPkg::aluOpAdd;
            end
            rvPkg::opStore:
            begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = rvPkg::immS;
                aluOp    = rvPkg::aluOpAdd;
            end
            rvPkg::opRType:
            begin
                regWrite = 1'b1;
                aluOp    = rvPkg::aluOpFunct;
            end
            rvPkg::opBranch:
            begin
                // beq compares via subtraction
                branch = 1'b1;
                immSrc = rvPkg::immB;
                aluOp  = rvPkg::aluOpSub;
            end
            rvPkg::opIType:
            begin
                aluSrc   = 1'b1;
                immSrc   = rvPkg::immI;
                regWrite = 1'b1;
                aluOp    = rvPkg::aluOpFunct;
            end
            rvPkg::opJal:
            begin
                jump     = 1'b1;
                resSrc   = rvPkg::resPcPlus4;
                immSrc   = rvPkg::immJ;
                regWrite = 1'b1;
            end
            default:
            begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/rvPkg.sv */
`default_nettype none

package rvPkg;

    // ########################################
    // opcodes
    // ########################################
    localparam logic [6:0] opLoad   = 7'd3;
    localparam logic [6:0] opStore  = 7'd35;
    localparam logic [6:0] opRType  = 7'd51;
    localparam logic [6:0] opBranch = 7'd99;
    localparam logic [6:0] opIType  = 7'd19;
    localparam logic [6:0] opJal    = 7'd111;

    // decoder code widths
    localparam int resSrcW  = 2;
    localparam int immSrcW  = 2;
    localparam int aluOpW   = 2;
    localparam int aluCtrlW = 3;

    // writeback source
    localparam logic [resSrcW-1:0] resAlu     = 2'b00;
    localparam logic [resSrcW-1:0] resMem     = 2'b01;
    localparam logic [resSrcW-1:0] resPcPlus4 = 2'b10;

    // immediate formats
    localparam logic [immSrcW-1:0] immI = 2'b00;
    localparam logic [immSrcW-1:0] immS = 2'b01;
    localparam logic [immSrcW-1:0] immB = 2'b10;
    localparam logic [immSrcW-1:0] immJ = 2'b11;

    // first-level alu selection
    localparam logic [aluOpW-1:0] aluOpAdd   = 2'b00;
    localparam logic [aluOpW-1:0] aluOpSub   = 2'b01;
    localparam logic [aluOpW-1:0] aluOpFunct = 2'b10;

    // alu operations
    localparam logic [aluCtrlW-1:0] aluAdd = 3'b000;
    localparam logic [aluCtrlW-1:0] aluSub = 3'b001;
    localparam logic [aluCtrlW-1:0] aluAnd = 3'b010;
    localparam logic [aluCtrlW-1:0] aluOr  = 3'b011;
    localparam logic [aluCtrlW-1:0] aluSlt = 3'b101;

    // ########################################
    // instruction word views
    // ########################################
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    // branch offset is scattered with bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10To5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4To1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10To1;
        logic       imm11;
        logic [7:0] imm19To12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        jTypeT j;
    } rvInstr;

endpackage

`default_nettype wire
